//--- logic/mod_pkg.sv
`default_nettype none

package mod_pkg;

  typedef logic [14:0] mod_idx_t;    // sample index in a segment.
  typedef logic [14:0] mod_cycle_t;  // last index of a loop.
  typedef logic [15:0] mod_div_t;    // clocks per index step.
  typedef logic [31:0] mod_rep_t;
  typedef logic [7:0]  mod_sample_t;
  typedef logic        mod_seg_t;

  localparam mod_rep_t REP_INFINITE = '1;

  typedef struct packed {
    mod_cycle_t cycle_0;
    mod_div_t   freq_div_0;
    mod_cycle_t cycle_1;
    mod_div_t   freq_div_1;
  } mod_cfg_t;

  typedef struct packed {
    mod_seg_t req_segment;
    mod_rep_t rep;
  } mod_req_t;

  typedef struct packed {
    mod_idx_t idx_0;
    mod_idx_t idx_1;
    logic     wrap_0;  // idx_0 just returned to 0.
    logic     wrap_1;
  } mod_tick_t;

  typedef struct packed {
    mod_seg_t segment;
    logic     stop;
    mod_idx_t idx;     // index of the active segment.
  } mod_cnt_t;

  typedef struct packed {
    logic        en;
    mod_seg_t    segment;
    mod_idx_t    addr;
    mod_sample_t data;
  } mod_wr_t;

  typedef enum logic [1:0] {
    ST_INFINITE,
    ST_WAIT_SWITCH,
    ST_FINITE,
    ST_STOPPED
  } swap_state_t;

endpackage

`default_nettype wire

//--- logic/mod_sample_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mod_sample_ram #(
  parameter int SAMPLE_DEPTH = 1024
) (
  input  wire logic              CLK,
  input  wire logic              rst_n,
  input  wire mod_pkg::mod_wr_t  wr,
  input  wire mod_pkg::mod_seg_t segment,
  input  wire mod_pkg::mod_idx_t idx,
  input  wire logic              stop,
  output mod_pkg::mod_sample_t   sample
);

  import mod_pkg::*;

  localparam int IDX_W = $clog2(SAMPLE_DEPTH);

  mod_sample_t mem [2][SAMPLE_DEPTH];

  logic [IDX_W-1:0] wr_addr;
  logic [IDX_W-1:0] rd_addr;

  assign wr_addr = wr.addr[IDX_W-1:0];
  assign rd_addr = idx[IDX_W-1:0];

  always_ff @(posedge CLK) begin
    if (wr.en) begin
      mem[wr.segment][wr_addr] <= wr.data;
    end
  end

  // read before write on a shared word.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sample <= '0;
    end else if (!stop) begin
      sample <= mem[segment][rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- logic/mod_swapchain.sv
`timescale 1ns/100ps
`default_nettype none

module mod_swapchain (
  input  wire logic               CLK,
  input  wire logic               rst_n,
  input  wire logic               update_settings,
  input  wire mod_pkg::mod_req_t  req,
  input  wire mod_pkg::mod_tick_t tick,
  output mod_pkg::mod_seg_t       segment,
  output logic                    stop,
  output mod_pkg::mod_idx_t       idx
);

  import mod_pkg::*;

  swap_state_t state;
  mod_seg_t    req_seg_r;  // pending segment.
  mod_rep_t    rep_r;
  mod_rep_t    loop_cnt;   // loops done since the switch.

  logic wrap_req;
  logic wrap_act;
  logic no_change;

  assign wrap_req = req_seg_r ? tick.wrap_1 : tick.wrap_0;
  assign wrap_act = segment ? tick.wrap_1 : tick.wrap_0;

  // infinite request for the playing segment, not stopped.
  assign no_change = (req.rep == REP_INFINITE) &&
                     (req.req_segment == segment) &&
                     (state != ST_STOPPED);

  assign idx = segment ? tick.idx_1 : tick.idx_0;

  always_ff @(posedge CLK) begin
    if (update_settings) begin
      req_seg_r <= req.req_segment;
      rep_r     <= req.rep;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= ST_INFINITE;
      segment  <= 1'b0;
      stop     <= 1'b0;
      loop_cnt <= '0;
    end else if (update_settings) begin
      // a new strobe replaces any pending request.
      if (no_change) begin
        state <= ST_INFINITE;
      end else begin
        state <= ST_WAIT_SWITCH;
        stop  <= 1'b0;
      end
    end else begin
      case (state)
        ST_WAIT_SWITCH: begin
          if (wrap_req) begin
            segment  <= req_seg_r;
            loop_cnt <= '0;
            state    <= (rep_r == REP_INFINITE) ? ST_INFINITE : ST_FINITE;
          end
        end
        ST_FINITE: begin
          if (wrap_act) begin
            if (loop_cnt == rep_r) begin
              state <= ST_STOPPED;
              stop  <= 1'b1;  // held until the next strobe.
            end else begin
              loop_cnt <= loop_cnt + mod_rep_t'(1);
            end
          end
        end
        ST_STOPPED: begin
          stop <= 1'b1;
        end
        default: begin
          state <= ST_INFINITE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/mod_timer.sv
`timescale 1ns/100ps
`default_nettype none

module mod_timer (
  input  wire logic              CLK,
  input  wire logic              rst_n,
  input  wire mod_pkg::mod_cfg_t cfg,
  output mod_pkg::mod_tick_t     tick
);

  import mod_pkg::*;

  mod_cycle_t cycle   [2];
  mod_div_t   div_eff [2];
  mod_div_t   pre     [2];
  mod_idx_t   idx     [2];
  logic       wrap    [2];

  // a divider of 0 runs at full rate.
  assign cycle[0]   = cfg.cycle_0;
  assign cycle[1]   = cfg.cycle_1;
  assign div_eff[0] = (cfg.freq_div_0 == '0) ? mod_div_t'(1) : cfg.freq_div_0;
  assign div_eff[1] = (cfg.freq_div_1 == '0) ? mod_div_t'(1) : cfg.freq_div_1;

  for (genvar g = 0; g < 2; g++) begin : g_seg
    logic step;
    logic last;

    assign step = (pre[g] == div_eff[g] - mod_div_t'(1));
    assign last = (idx[g] >= cycle[g]);

    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        pre[g]  <= '0;
        idx[g]  <= '0;
        wrap[g] <= 1'b0;
      end else if (step) begin
        pre[g] <= '0;
        if (last) begin
          idx[g]  <= '0;
          wrap[g] <= 1'b1;  // one cycle, with idx at 0.
        end else begin
          idx[g]  <= idx[g] + mod_idx_t'(1);
          wrap[g] <= 1'b0;
        end
      end else begin
        pre[g]  <= pre[g] + mod_div_t'(1);
        wrap[g] <= 1'b0;
      end
    end
  end

  assign tick = '{
    idx_0:  idx[0],
    idx_1:  idx[1],
    wrap_0: wrap[0],
    wrap_1: wrap[1]
  };

endmodule

`default_nettype wire

//--- logic/mod_top.sv
`timescale 1ns/100ps
`default_nettype none

module mod_top #(
  parameter int SAMPLE_DEPTH = 1024
) (
  input  wire logic              CLK,
  input  wire logic              rst_n,
  input  wire mod_pkg::mod_cfg_t cfg,
  input  wire logic              update_settings,
  input  wire mod_pkg::mod_req_t req,
  input  wire mod_pkg::mod_wr_t  wr,
  output mod_pkg::mod_cnt_t      cnt,
  output mod_pkg::mod_sample_t   sample
);

  import mod_pkg::*;

  mod_tick_t tick;
  mod_seg_t  segment;
  mod_idx_t  idx;
  logic      stop;

  mod_timer u_timer (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cfg   (cfg),
    .tick  (tick)
  );

  mod_swapchain u_swapchain (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .update_settings (update_settings),
    .req             (req),
    .tick            (tick),
    .segment         (segment),
    .stop            (stop),
    .idx             (idx)
  );

  mod_sample_ram #(
    .SAMPLE_DEPTH (SAMPLE_DEPTH)
  ) u_sample_ram (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wr      (wr),
    .segment (segment),
    .idx     (idx),
    .stop    (stop),
    .sample  (sample)
  );

  assign cnt = '{segment: segment, stop: stop, idx: idx};

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the modulation sequencer testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_mod_top \
  -f vlog.f \
  -o tb_mod_top

status=0
./obj_dir/tb_mod_top > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "simulation ended abnormally, see $LOG"
  exit 1
fi
echo "simulation passed"

//--- verification/mod_sva.sv
`timescale 1ns/100ps
`default_nettype none

module mod_sva (
  input wire logic                 CLK,
  input wire logic                 rst_n,
  input wire mod_pkg::mod_tick_t   tick,
  input wire mod_pkg::mod_seg_t    segment,
  input wire logic                 stop,
  input wire mod_pkg::swap_state_t state
);

  import mod_pkg::*;

  // new segment only right after its own wrap.
  a_switch_on_wrap: assert property (
    @(posedge CLK) disable iff (!rst_n)
      $changed(segment) |-> (segment ? $past(tick.wrap_1) : $past(tick.wrap_0))
  ) else $error("segment changed without a wrap of the new segment");

  a_stop_in_stopped: assert property (
    @(posedge CLK) disable iff (!rst_n)
      $rose(stop) |-> (state == ST_STOPPED)
  ) else $error("stop rose outside the stopped state");

  a_reset_state: assert property (
    @(posedge CLK) !rst_n |=> (state == ST_INFINITE) && !stop && (segment == 1'b0)
  ) else $error("wrong swapchain state after reset");

endmodule

bind mod_swapchain mod_sva u_sva (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .tick    (tick),
  .segment (segment),
  .stop    (stop),
  .state   (state)
);

`default_nettype wire

//--- verification/tb_mod_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mod_top;

  import mod_pkg::*;

  localparam int SAMPLE_DEPTH = 1024;
  localparam int N_ROUNDS     = 12;
  localparam int WAIT_MAX     = 100;  // longest loop is 21 steps of 4 clocks.
  localparam int STOP_MAX     = 400;
  localparam int HOLD         = 40;
  localparam int TOTAL_CYCLES = 8 + 2 * SAMPLE_DEPTH + 8
                              + N_ROUNDS * (WAIT_MAX + STOP_MAX + 2 * HOLD + 8);

  logic        CLK;
  logic        rst_n;
  mod_cfg_t    cfg;
  logic        update_settings;
  mod_req_t    req;
  mod_wr_t     wr;
  mod_cnt_t    cnt;
  mod_sample_t sample;

  // inputs for the next rising edge.
  logic     nx_rst_n;
  logic     nx_strobe;
  mod_req_t nx_req;
  mod_wr_t  nx_wr;
  logic     play_writes;

  // reference model state.
  int          m_pre   [2];
  int          m_idx   [2];
  logic        m_wrap  [2];
  swap_state_t m_state;
  mod_seg_t    m_seg;
  logic        m_stop;
  mod_rep_t    m_loops;
  mod_seg_t    m_req_seg;
  mod_rep_t    m_rep;
  mod_sample_t m_mem   [2][SAMPLE_DEPTH];
  bit          m_valid [2][SAMPLE_DEPTH];  // word written at least once.
  mod_sample_t m_sample;
  bit          m_sample_ok;

  integer seed;
  string  test_name;

  mod_top #(
    .SAMPLE_DEPTH (SAMPLE_DEPTH)
  ) u_dut (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .cfg             (cfg),
    .update_settings (update_settings),
    .req             (req),
    .wr              (wr),
    .cnt             (cnt),
    .sample          (sample)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    #(TOTAL_CYCLES * 80);
    abort_run($sformatf("watchdog: run still going after %0d cycles", TOTAL_CYCLES * 2));
  end

  function automatic int rand_between(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + r % (hi - lo + 1);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_idx(input string name, input mod_idx_t exp, input mod_idx_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s idx: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_seg(input string name, input mod_seg_t exp, input mod_seg_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s segment: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_stop(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s stop: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  task automatic check_sample(input string name, input mod_sample_t exp,
                              input mod_sample_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s sample: expected 0x%02h, actual 0x%02h", name, exp, act));
    end
  endtask

  // one clock of the reference, from the inputs seen at this edge.
  task automatic model_step();
    int          lim    [2];
    int          div    [2];
    int          n_pre  [2];
    int          n_idx  [2];
    logic        n_wrap [2];
    swap_state_t n_state;
    mod_seg_t    n_seg;
    logic        n_stop;
    mod_rep_t    n_loops;
    mod_sample_t n_sample;
    bit          n_ok;
    int          s;

    lim[0] = int'(cfg.cycle_0);
    lim[1] = int'(cfg.cycle_1);
    div[0] = (cfg.freq_div_0 == '0) ? 1 : int'(cfg.freq_div_0);
    div[1] = (cfg.freq_div_1 == '0) ? 1 : int'(cfg.freq_div_1);
    for (s = 0; s < 2; s++) begin
      n_pre[s]  = m_pre[s] + 1;
      n_idx[s]  = m_idx[s];
      n_wrap[s] = 1'b0;
      if (m_pre[s] + 1 >= div[s]) begin
        n_pre[s] = 0;
        if (m_idx[s] >= lim[s]) begin
          n_idx[s]  = 0;
          n_wrap[s] = 1'b1;
        end else begin
          n_idx[s] = m_idx[s] + 1;
        end
      end
    end

    n_state = m_state;
    n_seg   = m_seg;
    n_stop  = m_stop;
    n_loops = m_loops;
    if (update_settings) begin
      if (req.rep == REP_INFINITE && req.req_segment == m_seg && m_state != ST_STOPPED) begin
        n_state = ST_INFINITE;
      end else begin
        n_state = ST_WAIT_SWITCH;
        n_stop  = 1'b0;
      end
    end else if (m_state == ST_WAIT_SWITCH && m_wrap[m_req_seg]) begin
      n_seg   = m_req_seg;
      n_loops = '0;
      if (m_rep == REP_INFINITE) begin
        n_state = ST_INFINITE;
      end else begin
        n_state = ST_FINITE;
      end
    end else if (m_state == ST_FINITE && m_wrap[m_seg]) begin
      if (m_loops == m_rep) begin
        n_state = ST_STOPPED;
        n_stop  = 1'b1;
      end else begin
        n_loops = m_loops + mod_rep_t'(1);
      end
    end

    n_sample = m_sample;
    n_ok     = m_sample_ok;
    if (!m_stop) begin
      n_sample = m_mem[m_seg][m_idx[m_seg]];  // old data on a shared word.
      n_ok     = m_valid[m_seg][m_idx[m_seg]];
    end
    if (wr.en) begin
      m_mem[wr.segment][int'(wr.addr)]   = wr.data;
      m_valid[wr.segment][int'(wr.addr)] = 1'b1;
    end
    if (update_settings) begin
      m_req_seg = req.req_segment;
      m_rep     = req.rep;
    end

    if (!rst_n) begin
      for (s = 0; s < 2; s++) begin
        m_pre[s]  = 0;
        m_idx[s]  = 0;
        m_wrap[s] = 1'b0;
      end
      m_state     = ST_INFINITE;
      m_seg       = 1'b0;
      m_stop      = 1'b0;
      m_loops     = '0;
      m_sample    = '0;
      m_sample_ok = 1'b1;
    end else begin
      m_pre       = n_pre;
      m_idx       = n_idx;
      m_wrap      = n_wrap;
      m_state     = n_state;
      m_seg       = n_seg;
      m_stop      = n_stop;
      m_loops     = n_loops;
      m_sample    = n_sample;
      m_sample_ok = n_ok;
    end
  endtask

  // random write for the next edge, sometimes onto the word read there.
  task automatic pick_write();
    int r;
    r = rand_between(0, 7);
    if (r == 0) begin
      nx_wr = '{en: 1'b1, segment: m_seg, addr: mod_idx_t'(m_idx[m_seg]),
                data: mod_sample_t'($random(seed))};
    end else if (r < 4) begin
      nx_wr = '{en: 1'b1, segment: ~m_seg, addr: mod_idx_t'(rand_between(0, 31)),
                data: mod_sample_t'($random(seed))};
    end
  endtask

  task automatic check_outputs();
    check_seg(test_name, m_seg, cnt.segment);
    check_stop(test_name, m_stop, cnt.stop);
    check_idx(test_name, mod_idx_t'(m_idx[m_seg]), cnt.idx);
    if (m_sample_ok) begin
      check_sample(test_name, m_sample, sample);
    end
  endtask

  task automatic run_cycle();
    @(posedge CLK);
    model_step();
    if (play_writes) begin
      pick_write();
    end
    rst_n           <= nx_rst_n;
    update_settings <= nx_strobe;
    req             <= nx_req;
    wr              <= nx_wr;
    nx_strobe = 1'b0;
    nx_wr.en  = 1'b0;
    @(negedge CLK);
    check_outputs();
  endtask

  task automatic play_cycles(input int n);
    repeat (n) run_cycle();
  endtask

  task automatic send_request(input mod_seg_t seg, input mod_rep_t rep);
    nx_strobe = 1'b1;
    nx_req    = '{req_segment: seg, rep: rep};
    run_cycle();
    run_cycle();
  endtask

  task automatic wait_playing(input mod_seg_t target);
    int n;
    n = 0;
    while (cnt.segment !== target || m_state == ST_WAIT_SWITCH) begin
      if (n == WAIT_MAX) begin
        abort_run($sformatf("segment %0d did not start playing within %0d cycles",
                            target, WAIT_MAX));
      end else begin
        run_cycle();
        n++;
      end
    end
  endtask

  task automatic wait_stop();
    int n;
    n = 0;
    while (cnt.stop !== 1'b1) begin
      if (n == STOP_MAX) begin
        abort_run($sformatf("stop did not rise within %0d cycles", STOP_MAX));
      end else begin
        run_cycle();
        n++;
      end
    end
  endtask

  initial begin
    int          r;
    int          s;
    int          a;
    mod_seg_t    target;
    mod_rep_t    rep;
    mod_sample_t frozen;

    seed = 32'h96f50162;
    rst_n           <= 1'b0;
    update_settings <= 1'b0;
    req             <= '0;
    wr              <= '0;
    cfg <= '{cycle_0:    mod_cycle_t'(rand_between(3, 20)),
             freq_div_0: mod_div_t'(rand_between(1, 4)),
             cycle_1:    mod_cycle_t'(rand_between(3, 20)),
             freq_div_1: mod_div_t'(rand_between(1, 4))};
    nx_rst_n    = 1'b0;
    nx_strobe   = 1'b0;
    nx_req      = '0;
    nx_wr       = '0;
    play_writes = 1'b0;
    m_req_seg   = 1'b0;
    m_rep       = '0;
    for (s = 0; s < 2; s++) begin
      for (a = 0; a < SAMPLE_DEPTH; a++) begin
        m_valid[s][a] = 1'b0;
      end
    end

    test_name = "reset";
    play_cycles(7);
    nx_rst_n = 1'b1;
    run_cycle();

    test_name = "ram_fill";
    for (s = 0; s < 2; s++) begin
      for (a = 0; a < SAMPLE_DEPTH; a++) begin
        nx_wr = '{en: 1'b1, segment: mod_seg_t'(s), addr: mod_idx_t'(a),
                  data: mod_sample_t'($random(seed))};
        run_cycle();
      end
    end
    play_cycles(4);

    play_writes = 1'b1;
    for (r = 0; r < N_ROUNDS; r++) begin
      rep = mod_rep_t'(rand_between(0, 3));
      case (r % 4)
        0: begin
          test_name = "finite_other";
          target    = ~m_seg;
        end
        1: begin
          test_name = "finite_same";
          target    = m_seg;
        end
        2: begin
          test_name = "infinite_other";
          target    = ~m_seg;
          rep       = REP_INFINITE;
        end
        default: begin
          test_name = "finite_random";
          target    = mod_seg_t'(rand_between(0, 1));
        end
      endcase
      send_request(target, rep);
      wait_playing(target);
      if (rep != REP_INFINITE) begin
        wait_stop();
        frozen = m_sample;
        play_cycles(HOLD);
        check_sample({test_name, "_hold"}, frozen, sample);
      end else begin
        play_cycles(HOLD);
        test_name = "no_change";
        send_request(m_seg, REP_INFINITE);  // same segment, nothing visible.
        play_cycles(HOLD);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/mod_pkg.sv
logic/mod_timer.sv
logic/mod_swapchain.sv
logic/mod_sample_ram.sv
logic/mod_top.sv
verification/mod_sva.sv
verification/tb_mod_top.sv
